/* hw/sdadc_pkg.sv */
package sdadc_pkg;

    // Number of external modulators that share the one modulator clock
    localparam int n_channels = 4;
    localparam int channel_width = $clog2(n_channels);

    // System clocks per modulator clock period, split evenly into high and low halves
    localparam int mod_clock_div = 4;
    localparam int mod_half_period = mod_clock_div / 2;
    localparam int mod_count_width = $clog2(mod_half_period);

    // Third-order CIC with a fixed decimation ratio
    localparam int cic_order = 3;
    localparam int cic_decimation = 16;
    localparam int decim_count_width = $clog2(cic_decimation);

    // Bit growth is order times log2 of the ratio, on top of the one-bit input
    localparam int sample_width = cic_order * decim_count_width + 1;

    // Result words carry the channel tag above the sample
    localparam int result_width = channel_width + sample_width;

    localparam int fifo_depth = 8;
    localparam int fifo_addr_width = $clog2(fifo_depth);
    // One extra bit so that a full FIFO can be told apart from an empty one
    localparam int fifo_count_width = fifo_addr_width + 1;

    localparam int apb_addr_width = 4;
    localparam int apb_data_width = 32;

    // Register map
    localparam logic [apb_addr_width-1:0] reg_ctrl = 4'h0;
    localparam logic [apb_addr_width-1:0] reg_status = 4'h4;
    localparam logic [apb_addr_width-1:0] reg_data = 4'h8;
    localparam int ctrl_enable_bit = 0;
    localparam int status_overflow_bit = 8;

endpackage

/* hw/modulator_clock_gen.sv */
`timescale 1ns/1ps

module modulator_clock_gen
    import sdadc_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic enable,
    output logic modulator_clock,
    output logic sample_strobe
);

    // Counts system clocks within one half of the modulator period
    logic [mod_count_width-1:0] div_count;
    logic half_done;

    assign half_done = (div_count == mod_count_width'(mod_half_period - 1));

    always_ff @(posedge clock) begin
        if (reset || !enable) begin
            // Disabled, so the modulators see a quiet clock and the
            // divider restarts from a known phase on the next enable
            div_count <= '0;
            modulator_clock <= 1'b0;
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= 1'b0;
            if (half_done) begin
                div_count <= '0;
                modulator_clock <= !modulator_clock;
                // Strobe covers the first system cycle with the modulator clock high
                // The modulator output is stable there, since it changes after the fall
                sample_strobe <= !modulator_clock;
            end else begin
                div_count <= div_count + 1'b1;
            end
        end
    end

endmodule

/* hw/cic_decimator.sv */
`timescale 1ns/1ps

module cic_decimator
    import sdadc_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic sample_strobe,
    input  logic bit_in,
    output logic [sample_width-1:0] sample,
    output logic sample_valid
);

    // Integrator and comb state, one entry per stage
    logic [sample_width-1:0] integ [cic_order];
    logic [sample_width-1:0] integ_next [cic_order];
    logic [sample_width-1:0] comb_delay [cic_order];
    logic [sample_width-1:0] comb_out [cic_order];

    // Strobes seen since the last output sample
    logic [decim_count_width-1:0] decim_count;
    logic decimate;

    // Every 16th strobe produces an output
    assign decimate = sample_strobe &&
                      (decim_count == decim_count_width'(cic_decimation - 1));

    always_comb begin
        // Cascaded integrators, each one fed by the updated value of the one before
        // The arithmetic wraps at sample_width, which is exact for CIC filters
        integ_next[0] = integ[0] + sample_width'(bit_in);
        for (int i = 1; i < cic_order; i++) begin
            integ_next[i] = integ[i] + integ_next[i-1];
        end

        // Comb stages work at the decimated rate with a differential delay of one
        comb_out[0] = integ_next[cic_order-1] - comb_delay[0];
        for (int i = 1; i < cic_order; i++) begin
            comb_out[i] = comb_out[i-1] - comb_delay[i];
        end
    end

    always_ff @(posedge clock) begin
        if (reset || !enable) begin
            // Disabling conversion restarts the filter from zero
            for (int i = 0; i < cic_order; i++) begin
                integ[i] <= '0;
                comb_delay[i] <= '0;
            end
            decim_count <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= decimate;
            if (sample_strobe) begin
                for (int i = 0; i < cic_order; i++) begin
                    integ[i] <= integ_next[i];
                end
                // Counter width matches the ratio, so it wraps back to zero by itself
                decim_count <= decim_count + 1'b1;
            end
            if (decimate) begin
                // Each comb stage remembers its input for the next decimated sample
                comb_delay[0] <= integ_next[cic_order-1];
                for (int i = 1; i < cic_order; i++) begin
                    comb_delay[i] <= comb_out[i-1];
                end
            end
        end
    end

    // Output register, valid together with the sample_valid pulse
    always_ff @(posedge clock) begin
        if (decimate) begin
            sample <= comb_out[cic_order-1];
        end
    end

endmodule

/* hw/output_combiner.sv */
`timescale 1ns/1ps

module output_combiner
    import sdadc_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic [n_channels-1:0][sample_width-1:0] sample_in,
    input  logic sample_valid,
    output logic [result_width-1:0] result,
    output logic result_valid
);

    // Snapshot of every channel, taken when the decimators report
    logic [n_channels-1:0][sample_width-1:0] latched;

    // Two-state FSM, idle while low and emitting while high
    logic busy;
    // Channel being emitted in the current cycle
    logic [channel_width-1:0] channel;

    always_ff @(posedge clock) begin
        if (sample_valid) begin
            latched <= sample_in;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            channel <= '0;
        end else if (!busy) begin
            // All decimators share the strobe, so one valid covers every channel
            if (sample_valid) begin
                busy <= 1'b1;
                channel <= '0;
            end
        end else begin
            if (channel == channel_width'(n_channels - 1)) begin
                busy <= 1'b0;
                channel <= '0;
            end else begin
                channel <= channel + 1'b1;
            end
        end
    end

    // One tagged word per cycle while emitting, channel 0 first
    // Decimator outputs come every 64 cycles, far apart from the 4-cycle burst
    // There is no ready input, the FIFO drops what it cannot take
    assign result_valid = busy;
    assign result = {channel, latched[channel]};

endmodule

/* hw/result_fifo.sv */
`timescale 1ns/1ps

module result_fifo
    import sdadc_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic push,
    input  logic [result_width-1:0] push_data,
    input  logic pop,
    output logic [result_width-1:0] head,
    output logic [fifo_count_width-1:0] count,
    output logic overflow,
    input  logic overflow_clear
);

    logic [result_width-1:0] mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign full = (count == fifo_count_width'(fifo_depth));
    assign empty = (count == '0);

    // Pushes into a full FIFO are lost, pops from an empty one do nothing
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            // Depth is a power of two, so the pointers wrap without a compare
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fifo_count_width'(do_push) - fifo_count_width'(do_pop);
            // A new drop wins over a clear in the same cycle, so no loss goes unseen
            if (push && full) begin
                overflow <= 1'b1;
            end else if (overflow_clear) begin
                overflow <= 1'b0;
            end
        end
    end

    // Oldest word, readable the cycle after it was pushed
    assign head = mem[rd_ptr];

endmodule

/* hw/apb_readout.sv */
`timescale 1ns/1ps

module apb_readout
    import sdadc_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic [apb_addr_width-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [apb_data_width-1:0] pwdata,
    output logic [apb_data_width-1:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic enable,
    input  logic [result_width-1:0] fifo_head,
    input  logic [fifo_count_width-1:0] fifo_count,
    input  logic fifo_overflow,
    output logic pop,
    output logic overflow_clear
);

    logic access;
    logic ctrl_write;
    logic fifo_empty;
    logic [apb_data_width-1:0] status_word;

    // Access phase of a transfer, it always completes in one cycle
    assign access = psel && penable;
    assign pready = 1'b1;

    assign ctrl_write = access && pwrite && (paddr == reg_ctrl);
    assign fifo_empty = (fifo_count == '0);

    // STATUS holds the FIFO count in the low bits and the sticky overflow flag
    always_comb begin
        status_word = '0;
        status_word[fifo_count_width-1:0] = fifo_count;
        status_word[status_overflow_bit] = fifo_overflow;
    end

    // Enable is the only stored register, the others reflect FIFO state
    always_ff @(posedge clock) begin
        if (reset) begin
            enable <= 1'b0;
        end else if (ctrl_write) begin
            enable <= pwdata[ctrl_enable_bit];
        end
    end

    // Read data, error and the FIFO side pulses all come from the access phase
    always_comb begin
        prdata = '0;
        pslverr = 1'b0;
        pop = 1'b0;
        overflow_clear = 1'b0;
        if (access) begin
            case (paddr)
                reg_ctrl: begin
                    prdata[ctrl_enable_bit] = enable;
                end
                reg_status: begin
                    if (pwrite) begin
                        // Write one to clear the overflow flag
                        overflow_clear = pwdata[status_overflow_bit];
                    end else begin
                        prdata = status_word;
                    end
                end
                reg_data: begin
                    // Writes to DATA have no effect
                    if (!pwrite) begin
                        if (fifo_empty) begin
                            // Reading an empty FIFO returns zero and flags the error
                            pslverr = 1'b1;
                        end else begin
                            prdata = apb_data_width'(fifo_head);
                            pop = 1'b1;
                        end
                    end
                end
                default: begin
                    pslverr = 1'b1;
                end
            endcase
        end
    end

endmodule

/* hw/sdadc_top.sv */
`timescale 1ns/1ps

module sdadc_top
    import sdadc_pkg::*;
(
    input  logic clock,
    input  logic reset,
    // APB slave port
    input  logic [apb_addr_width-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [apb_data_width-1:0] pwdata,
    output logic [apb_data_width-1:0] prdata,
    output logic pready,
    output logic pslverr,
    // Shared clock out to the modulators and their returned bitstreams
    output logic modulator_clock,
    input  logic [n_channels-1:0] bitstream
);

    logic enable;
    logic sample_strobe;
    logic [n_channels-1:0][sample_width-1:0] channel_sample;
    logic [n_channels-1:0] channel_valid;
    logic [result_width-1:0] result;
    logic result_valid;
    logic fifo_pop;
    logic [result_width-1:0] fifo_head;
    logic [fifo_count_width-1:0] fifo_count;
    logic fifo_overflow;
    logic overflow_clear;

    modulator_clock_gen i_modulator_clock_gen (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .modulator_clock(modulator_clock),
        .sample_strobe(sample_strobe)
    );

    // One decimator per modulator, all sampled by the same strobe
    for (genvar ch = 0; ch < n_channels; ch++) begin : g_channel
        cic_decimator i_cic_decimator (
            .clock(clock),
            .reset(reset),
            .enable(enable),
            .sample_strobe(sample_strobe),
            .bit_in(bitstream[ch]),
            .sample(channel_sample[ch]),
            .sample_valid(channel_valid[ch])
        );
    end

    // The valids pulse together, so the combiner starts once all channels report
    output_combiner i_output_combiner (
        .clock(clock),
        .reset(reset),
        .sample_in(channel_sample),
        .sample_valid(&channel_valid),
        .result(result),
        .result_valid(result_valid)
    );

    result_fifo i_result_fifo (
        .clock(clock),
        .reset(reset),
        .push(result_valid),
        .push_data(result),
        .pop(fifo_pop),
        .head(fifo_head),
        .count(fifo_count),
        .overflow(fifo_overflow),
        .overflow_clear(overflow_clear)
    );

    apb_readout i_apb_readout (
        .clock(clock),
        .reset(reset),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .enable(enable),
        .fifo_head(fifo_head),
        .fifo_count(fifo_count),
        .fifo_overflow(fifo_overflow),
        .pop(fifo_pop),
        .overflow_clear(overflow_clear)
    );

endmodule

/* test/sdadc_model.svh */
`ifndef SDADC_MODEL_SVH
`define SDADC_MODEL_SVH

// Reference model of the readout path, included inside the testbench module
// Each channel is a third-order CIC with a differential delay of one
// All state is held at the sample width, so sums and differences wrap like a CIC should
logic [sample_width-1:0] model_integ [n_channels][cic_order];
logic [sample_width-1:0] model_comb [n_channels][cic_order];

// Modulator bits fed to the model since the last restart
int model_bit_count;

// Conversion restarts from zero whenever enable is cleared
function automatic void model_reset();
    for (int ch = 0; ch < n_channels; ch++) begin
        for (int s = 0; s < cic_order; s++) begin
            model_integ[ch][s] = '0;
            model_comb[ch][s] = '0;
        end
    end
    model_bit_count = 0;
endfunction

// Runs one modulator bit through the integrator chain of a channel
// On a decimation bit the integrator output also goes down the comb chain,
// and the return value is then the decimated sample
function automatic logic [sample_width-1:0] cic_advance(input int ch, input logic bit_value,
                                                       input logic decimate);
    logic [sample_width-1:0] stage;
    logic [sample_width-1:0] delayed;
    stage = sample_width'(bit_value);
    for (int s = 0; s < cic_order; s++) begin
        model_integ[ch][s] = model_integ[ch][s] + stage;
        stage = model_integ[ch][s];
    end
    if (decimate) begin
        // y[n] = x[n] - x[n-1] at the decimated rate, three times over
        for (int s = 0; s < cic_order; s++) begin
            delayed = model_comb[ch][s];
            model_comb[ch][s] = stage;
            stage = stage - delayed;
        end
    end
    return stage;
endfunction

// Result words carry the channel number above the unsigned sample
function automatic logic [result_width-1:0] pack_result(input int ch,
                                                       input logic [sample_width-1:0] value);
    logic [channel_width-1:0] tag;
    tag = channel_width'(ch);
    return {tag, value};
endfunction

`endif

/* test/sdadc_tb.sv */
`timescale 1ns/1ps

module sdadc_tb
    import sdadc_pkg::*;
();

    logic clock;
    logic reset;
    logic [apb_addr_width-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [apb_data_width-1:0] pwdata;
    logic [apb_data_width-1:0] prdata;
    logic pready;
    logic pslverr;
    logic modulator_clock;
    // Channels 0 and 1 are random, channel 2 is held at one and channel 3 at zero
    logic [n_channels-1:0] bitstream = 4'b0100;

    // Expected result words in the order the DUT should deliver them
    logic [result_width-1:0] expected_q [$];
    integer seed = 32'hcfc9;
    logic mod_clock_prev = 1'b0;
    // System clocks seen since the last rising edge of the modulator clock
    int rise_spacing = 0;
    // The main sequence asks for a model restart by bumping the request count
    int restart_count = 1;
    int restart_seen = 0;

    `include "sdadc_model.svh"

    sdadc_top i_sdadc_top (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // New random bits for channels 0 and 1, the other two stay constant
    function automatic logic [n_channels-1:0] draw_bits();
        logic [31:0] word;
        word = $random(seed);
        return {1'b0, 1'b1, word[1:0]};
    endfunction

    // Feeds one modulator period's bits to the model and queues the words it predicts
    function automatic void log_modulator_bits(input logic [n_channels-1:0] bits);
        logic decimate;
        logic [sample_width-1:0] value;
        model_bit_count++;
        decimate = (model_bit_count % cic_decimation == 0);
        for (int ch = 0; ch < n_channels; ch++) begin
            value = cic_advance(ch, bits[ch], decimate);
            if (decimate) begin
                expected_q.push_back(pack_result(ch, value));
            end
        end
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("Error at time %0t: %s is 0x%0h, expected 0x%0h",
                                      $time, what, actual, expected));
        end
    endtask

    // Modulator model and reference feed
    // Bits change on the first falling edge after modulator_clock falls, and the bit of a
    // period is logged on the first falling edge after it rises, while the strobe is high
    always @(negedge clock) begin
        if (restart_seen != restart_count) begin
            model_reset();
            expected_q.delete();
            restart_seen = restart_count;
        end else if (mod_clock_prev && !modulator_clock) begin
            bitstream = draw_bits();
        end else if (!mod_clock_prev && modulator_clock) begin
            // Once running, rising edges come one modulator period apart
            if (model_bit_count != 0) begin
                check_value("modulator_clock period in cycles", 32'(rise_spacing),
                            32'(mod_clock_div));
            end
            rise_spacing = 0;
            log_modulator_bits(bitstream);
        end
        rise_spacing++;
        mod_clock_prev = modulator_clock;
    end

    // One APB transfer, setup and access phase driven on falling edges
    task automatic apb_transfer(input logic [apb_addr_width-1:0] addr, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        @(negedge clock);
        paddr = addr;
        pwrite = write;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge clock);
        penable = 1'b1;
        // Sample halfway to the completing edge, where read data is settled
        #2;
        waited = 0;
        while (pready !== 1'b1) begin
            if (waited == 16) begin
                stop_on_failure("The APB slave never completed the access phase");
            end else begin
                waited++;
                @(posedge clock);
                #2;
            end
        end
        rdata = prdata;
        err = pslverr;
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic read_reg(input logic [apb_addr_width-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(addr, 1'b0, 32'h0, data, err);
    endtask

    // Writes only go to mapped registers, so none of them may flag an error
    task automatic write_reg(input logic [apb_addr_width-1:0] addr, input logic [31:0] data);
        logic [31:0] unused_data;
        logic err;
        apb_transfer(addr, 1'b1, data, unused_data, err);
        check_value("write pslverr", 32'(err), 32'h0);
    endtask

    // Polls STATUS until one of the masked bits is set
    task automatic wait_for_status(input logic [31:0] mask, input int max_polls,
                                   input string what);
        logic [31:0] status;
        logic err;
        int polls;
        polls = 0;
        read_reg(reg_status, status, err);
        check_value("STATUS pslverr", 32'(err), 32'h0);
        while ((status & mask) == 32'h0) begin
            if (polls == max_polls) begin
                stop_on_failure($sformatf("Timed out waiting for %s in STATUS", what));
            end else begin
                polls++;
                read_reg(reg_status, status, err);
                check_value("STATUS pslverr", 32'(err), 32'h0);
            end
        end
    endtask

    // Pops words one by one and checks each against the model
    // first_index counts words since the last restart, four per decimation period
    task automatic compare_words(input int n_words, input int first_index);
        logic [31:0] data;
        logic err;
        logic [result_width-1:0] expected;
        int period;
        int tag;
        for (int i = 0; i < n_words; i++) begin
            wait_for_status(32'((1 << fifo_count_width) - 1), 100, "a result word");
            read_reg(reg_data, data, err);
            check_value("DATA pslverr", 32'(err), 32'h0);
            if (expected_q.size() == 0) begin
                stop_on_failure("The DUT returned a result word that the model did not predict");
            end else begin
                expected = expected_q.pop_front();
                check_value("DATA word", data, 32'(expected));
                // After three periods the filter has forgotten its zero start
                period = (first_index + i) / n_channels;
                tag = int'(data[result_width-1:sample_width]);
                if (period >= cic_order && tag == 2) begin
                    check_value("constant one channel", 32'(data[sample_width-1:0]),
                                32'(cic_decimation ** cic_order));
                end else if (period >= cic_order && tag == 3) begin
                    check_value("constant zero channel", 32'(data[sample_width-1:0]), 32'h0);
                end
            end
        end
    endtask

    initial begin
        logic [31:0] data;
        logic err;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        reset = 1'b1;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        // Disabled, the modulators get no clock and the FIFO is empty
        for (int i = 0; i < 32; i++) begin
            @(negedge clock);
            check_value("modulator_clock while disabled", 32'(modulator_clock), 32'h0);
        end
        read_reg(reg_status, data, err);
        check_value("STATUS after reset", data, 32'h0);
        check_value("STATUS pslverr", 32'(err), 32'h0);
        read_reg(reg_data, data, err);
        check_value("DATA from empty FIFO", data, 32'h0);
        check_value("DATA pslverr on empty FIFO", 32'(err), 32'h1);

        // Twenty decimation periods from the start, transient included
        write_reg(reg_ctrl, 32'h1);
        compare_words(20 * n_channels, 0);

        // Stop reading until the FIFO fills and drops words
        wait_for_status(32'h1 << status_overflow_bit, 200, "the overflow flag");
        read_reg(reg_status, data, err);
        check_value("STATUS when full", data,
                    32'(fifo_depth) | (32'h1 << status_overflow_bit));
        write_reg(reg_ctrl, 32'h0);
        // A burst already on its way from the last strobe still reaches the full FIFO
        repeat (8) @(negedge clock);
        compare_words(fifo_depth, 20 * n_channels);
        read_reg(reg_status, data, err);
        check_value("STATUS after draining", data, 32'h1 << status_overflow_bit);
        write_reg(reg_status, 32'h1 << status_overflow_bit);
        read_reg(reg_status, data, err);
        check_value("STATUS after overflow clear", data, 32'h0);

        // Restart from zero and follow a fresh model
        restart_count++;
        write_reg(reg_ctrl, 32'h1);
        compare_words(6 * n_channels, 0);
        read_reg(4'hc, data, err);
        check_value("unmapped read data", data, 32'h0);
        check_value("unmapped read pslverr", 32'(err), 32'h1);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+test
hw/sdadc_pkg.sv
hw/modulator_clock_gen.sv
hw/cic_decimator.sv
hw/output_combiner.sv
hw/result_fifo.sv
hw/apb_readout.sv
hw/sdadc_top.sv
test/sdadc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module sdadc_tb -f filelist.f \
    -Mdir obj_dir -o sdadc_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sdadc_sim > sim.log 2>&1
grep -q "^Testbench passed$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
